//--- hw/board_geom_pkg.sv
// board geometry types

// --------------------------------------------------
// pixel and grid geometry shared by the drawing blocks
// --------------------------------------------------
package board_geom_pkg;

    // screen coordinate in pixels
    // covers a 2048 pixel wide canvas
    typedef logic [10:0] coord_t;

    // side length of one square button
    // up to 127 pixels
    typedef logic [6:0] bsize_t;

    // row or column index inside the grid
    // also used for the button count per side
    typedef logic [4:0] idx_t;

endpackage

//--- hw/apb_map_pkg.sv
// apb register map

// --------------------------------------------------
// register offsets and bus level types
// --------------------------------------------------
package apb_map_pkg;

    // byte address on the apb side
    typedef logic [7:0] apb_addr_t;

    // 12 bit rgb, 4 bits per channel
    typedef logic [11:0] color_t;

    // board settings, one 32 bit word each
    localparam apb_addr_t REG_BOARD_X = 8'h00;
    localparam apb_addr_t REG_BOARD_Y = 8'h04;
    localparam apb_addr_t REG_BTN_SIZE = 8'h08;
    // buttons per side, 1 to 31
    localparam apb_addr_t REG_BTN_NUM = 8'h0C;
    localparam apb_addr_t REG_FILL = 8'h10;
    localparam apb_addr_t REG_BORDER = 8'h14;

    // control and status
    // ctrl bit 0 starts a board, write only
    localparam apb_addr_t REG_CTRL = 8'h18;
    // status bit 0 busy, bit 1 sticky done
    localparam apb_addr_t REG_STATUS = 8'h1C;

endpackage

//--- hw/board_settings_apb.sv
// board settings register bank
`timescale 1ns/1ps

module board_settings_apb import board_geom_pkg::*, apb_map_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        busy,
    input  logic        board_done,
    output coord_t      board_x,
    output coord_t      board_y,
    output bsize_t      btn_size,
    output idx_t        btn_num,
    output color_t      fill_color,
    output color_t      border_color,
    output logic        start
);

    logic wr_en;
    logic settings_hit;
    logic start_req;
    logic done_q;

    // --------------------------------------------------
    // access decode
    // --------------------------------------------------
    // no wait states, access ends in its access phase
    assign pready = 1'b1;
    assign wr_en = psel && penable && pwrite;

    // address falls on one of the six settings words
    assign settings_hit = (paddr == REG_BOARD_X) || (paddr == REG_BOARD_Y) ||
                          (paddr == REG_BTN_SIZE) || (paddr == REG_BTN_NUM) ||
                          (paddr == REG_FILL) || (paddr == REG_BORDER);

    // start bit written to ctrl
    assign start_req = wr_en && (paddr == REG_CTRL) && pwdata[0];

    // only a board with buttons, and only when idle
    assign start = start_req && !busy && (btn_num != '0);

    // settings locked while drawing
    // a refused start also reports an error
    assign pslverr = (wr_en && settings_hit && busy) || (start_req && !start);

    // --------------------------------------------------
    // settings registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            board_x <= '0;
            board_y <= '0;
            btn_size <= '0;
            btn_num <= '0;
            fill_color <= '0;
            border_color <= '0;
        end else if (wr_en && !busy) begin
            // upper bits of pwdata dropped
            case (paddr)
                REG_BOARD_X: board_x <= pwdata[$bits(coord_t)-1:0];
                REG_BOARD_Y: board_y <= pwdata[$bits(coord_t)-1:0];
                REG_BTN_SIZE: btn_size <= pwdata[$bits(bsize_t)-1:0];
                REG_BTN_NUM: btn_num <= pwdata[$bits(idx_t)-1:0];
                REG_FILL: fill_color <= pwdata[$bits(color_t)-1:0];
                REG_BORDER: border_color <= pwdata[$bits(color_t)-1:0];
                default: ;
            endcase
        end
    end

    // sticky done, a new start wins over a finishing board
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (start) begin
            done_q <= 1'b0;
        end else if (board_done) begin
            done_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        case (paddr)
            REG_BOARD_X: prdata = 32'(board_x);
            REG_BOARD_Y: prdata = 32'(board_y);
            REG_BTN_SIZE: prdata = 32'(btn_size);
            REG_BTN_NUM: prdata = 32'(btn_num);
            REG_FILL: prdata = 32'(fill_color);
            REG_BORDER: prdata = 32'(border_color);
            // done shows up on the edge busy falls
            REG_STATUS: prdata = {30'd0, done_q || board_done, busy};
            default: prdata = '0;
        endcase
    end

endmodule

//--- hw/tile_counter.sv
// wrapping grid index counter
`timescale 1ns/1ps

module tile_counter import board_geom_pkg::*; #(
    parameter int CNT_W = $bits(idx_t)
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic advance,
    input  idx_t max,
    output idx_t count,
    output logic wrap
);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] last_val;

    // last index before returning to zero
    assign last_val = CNT_W'(max) - CNT_W'(1);

    // wrap flag only on the advance that rolls over
    assign wrap = advance && (cnt_q == last_val);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cnt_q <= '0;
        end else if (advance) begin
            cnt_q <= (cnt_q == last_val) ? '0 : cnt_q + CNT_W'(1);
        end
    end

    assign count = idx_t'(cnt_q);

endmodule

//--- hw/draw_board.sv
// board scanner
`timescale 1ns/1ps

module draw_board import board_geom_pkg::*; #(
    parameter int CNT_W = $bits(idx_t)
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  coord_t board_x,
    input  coord_t board_y,
    input  bsize_t btn_size,
    input  idx_t   btn_num,
    input  logic   btn_done,
    output logic   busy,
    output logic   board_done,
    output logic   btn_req,
    output coord_t btn_x,
    output coord_t btn_y,
    output bsize_t btn_size_out
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } state_t;

    state_t state, state_nxt;

    idx_t col_idx, row_idx;
    logic col_adv;
    logic col_wrap, row_wrap;
    coord_t col_off, row_off;

    // --------------------------------------------------
    // grid counters
    // --------------------------------------------------
    // columns step per finished button
    assign col_adv = (state == WAIT) && btn_done;

    tile_counter #(.CNT_W(CNT_W)) col_counter (
        .clk, .rst, .clear(start), .advance(col_adv),
        .max(btn_num), .count(col_idx), .wrap(col_wrap)
    );

    // rows step when a column sweep rolls over
    tile_counter #(.CNT_W(CNT_W)) row_counter (
        .clk, .rst, .clear(start), .advance(col_wrap),
        .max(btn_num), .count(row_idx), .wrap(row_wrap)
    );

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            IDLE: state_nxt = start ? REQ : IDLE;
            REQ: state_nxt = WAIT;
            // a row wrap means the last button just finished
            WAIT: begin
                if (btn_done) begin
                    state_nxt = row_wrap ? DONE : REQ;
                end else begin
                    state_nxt = WAIT;
                end
            end
            DONE: state_nxt = start ? REQ : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // --------------------------------------------------
    // registered outputs
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            board_done <= 1'b0;
            btn_req <= 1'b0;
        end else begin
            busy <= (state_nxt == REQ) || (state_nxt == WAIT);
            board_done <= (state_nxt == DONE);
            // one cycle per button, right after REQ
            btn_req <= (state == REQ);
        end
    end

    // button offset from the board origin
    assign col_off = coord_t'(col_idx) * coord_t'(btn_size);
    assign row_off = coord_t'(row_idx) * coord_t'(btn_size);

    always_ff @(posedge clk) begin
        if (state == REQ) begin
            btn_x <= board_x + col_off;
            btn_y <= board_y + row_off;
            btn_size_out <= btn_size;
        end
    end

endmodule

//--- hw/draw_button.sv
// button rasterizer
`timescale 1ns/1ps

module draw_button import board_geom_pkg::*, apb_map_pkg::*; #(
    parameter int BORDER_W = 2
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   btn_req,
    input  coord_t btn_x,
    input  coord_t btn_y,
    input  bsize_t btn_size,
    input  color_t fill_color,
    input  color_t border_color,
    output logic   btn_done,
    output logic   pix_valid,
    output coord_t pix_x,
    output coord_t pix_y,
    output color_t pix_color,
    input  logic   pix_ready
);

    typedef enum logic {
        IDLE,
        EMIT
    } state_t;

    state_t state;

    coord_t x0_q, y0_q;
    bsize_t size_q;
    bsize_t col_q, row_q;
    bsize_t last_off, border_lo, border_hi;
    logic accept;
    logic col_last, row_last;
    logic on_border;

    // --------------------------------------------------
    // handshake and position
    // --------------------------------------------------
    assign pix_valid = (state == EMIT);
    assign accept = pix_valid && pix_ready;

    assign last_off = size_q - bsize_t'(1);
    assign col_last = (col_q == last_off);
    assign row_last = (row_q == last_off);

    // held steady until the pixel is taken
    assign pix_x = x0_q + coord_t'(col_q);
    assign pix_y = y0_q + coord_t'(row_q);

    // --------------------------------------------------
    // colour select
    // --------------------------------------------------
    // border band on each of the four edges
    assign border_lo = bsize_t'(BORDER_W);
    assign border_hi = size_q - bsize_t'(BORDER_W);
    assign on_border = (col_q < border_lo) || (col_q >= border_hi) ||
                       (row_q < border_lo) || (row_q >= border_hi);
    assign pix_color = on_border ? border_color : fill_color;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            btn_done <= 1'b0;
        end else begin
            btn_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (btn_req) begin
                        // empty button, finish at once
                        if (btn_size == '0) begin
                            btn_done <= 1'b1;
                        end else begin
                            state <= EMIT;
                        end
                    end
                end
                EMIT: begin
                    // last pixel taken
                    if (accept && col_last && row_last) begin
                        state <= IDLE;
                        btn_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request latch and row-major scan offsets
    always_ff @(posedge clk) begin
        if ((state == IDLE) && btn_req) begin
            x0_q <= btn_x;
            y0_q <= btn_y;
            size_q <= btn_size;
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            if (col_last) begin
                col_q <= '0;
                row_q <= row_q + bsize_t'(1);
            end else begin
                col_q <= col_q + bsize_t'(1);
            end
        end
    end

endmodule

//--- hw/board_renderer_top.sv
// board renderer top level
`timescale 1ns/1ps

module board_renderer_top import board_geom_pkg::*, apb_map_pkg::*; #(
    parameter int BORDER_W = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        pix_valid,
    input  logic        pix_ready,
    output coord_t      pix_x,
    output coord_t      pix_y,
    output color_t      pix_color,
    output logic        board_done
);

    // grid counters follow the index type
    localparam int CNT_W = $bits(idx_t);

    coord_t board_x, board_y;
    bsize_t btn_size;
    idx_t   btn_num;
    color_t fill_color, border_color;
    logic   start;
    logic   busy;

    // scanner to rasterizer
    logic   btn_req;
    logic   btn_done;
    coord_t btn_x, btn_y;
    bsize_t btn_size_out;

    // --------------------------------------------------
    // register bank
    // --------------------------------------------------
    board_settings_apb settings0 (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .busy, .board_done,
        .board_x, .board_y, .btn_size, .btn_num,
        .fill_color, .border_color, .start
    );

    // --------------------------------------------------
    // scanner and rasterizer
    // --------------------------------------------------
    draw_board #(.CNT_W(CNT_W)) board0 (
        .clk, .rst, .start, .board_x, .board_y, .btn_size, .btn_num,
        .btn_done, .busy, .board_done, .btn_req, .btn_x, .btn_y,
        .btn_size_out
    );

    draw_button #(.BORDER_W(BORDER_W)) button0 (
        .clk, .rst, .btn_req, .btn_x, .btn_y, .btn_size(btn_size_out),
        .fill_color, .border_color, .btn_done, .pix_valid,
        .pix_x, .pix_y, .pix_color, .pix_ready
    );

endmodule

//--- include/apb_tasks.svh
// apb bus tasks
`ifndef APB_TASKS_SVH
`define APB_TASKS_SVH

// --------------------------------------------------
// single write, returns the slave error flag
// --------------------------------------------------
task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
    // setup phase
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    // access phase, zero wait states
    @(negedge clk);
    penable = 1'b1;
    // response settles well before the rising edge
    #1;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

// --------------------------------------------------
// single read
// --------------------------------------------------
task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
endtask

`endif

//--- dv/board_renderer_tb.sv
// board renderer testbench
`timescale 1ns/1ps

module board_renderer_tb import board_geom_pkg::*, apb_map_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    // same as the top level default
    localparam int BORDER_W = 2;
    localparam int N_BOARDS = 4;
    // largest board, 4x4 buttons of 12x12 pixels
    localparam int MAX_PIX = 16 * 144;
    localparam int BOARD_TIMEOUT = MAX_PIX * 8;
    // random boards twice, plus three directed boards
    localparam int TOTAL_BOARDS = 2 * N_BOARDS + 3;
    localparam int WATCHDOG_CYCLES = TOTAL_BOARDS * MAX_PIX * 4 + 2000;
    localparam apb_addr_t SETTINGS_REGS [6] = '{REG_BOARD_X, REG_BOARD_Y, REG_BTN_SIZE,
                                                REG_BTN_NUM, REG_FILL, REG_BORDER};

    logic        clk;
    logic        rst;
    logic        psel, penable, pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        pix_valid, pix_ready;
    coord_t      pix_x, pix_y;
    color_t      pix_color;
    logic        board_done;

    integer seed = 32'h759edcce;
    int errors = 0;
    int checks = 0;
    int done_count = 0;
    int pix_count = 0;
    int done_before = 0;
    logic random_ready = 1'b0;

    // expected pixel stream
    coord_t exp_x[$];
    coord_t exp_y[$];
    color_t exp_c[$];

    // current board settings
    coord_t cur_x, cur_y;
    bsize_t cur_size;
    idx_t   cur_num;
    color_t cur_fill, cur_border;

    // stalled pixel, must hold
    logic   stall_q = 1'b0;
    coord_t hold_x, hold_y;
    color_t hold_c;

    board_renderer_top #(.BORDER_W(BORDER_W)) dut0 (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .pix_valid, .pix_ready, .pix_x, .pix_y,
        .pix_color, .board_done
    );

    `include "apb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // check helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got == exp) else begin
            $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    function automatic logic [31:0] reg_mask(input apb_addr_t addr);
        case (addr)
            REG_BOARD_X, REG_BOARD_Y: return 32'h7FF;
            REG_BTN_SIZE: return 32'h7F;
            REG_BTN_NUM: return 32'h1F;
            default: return 32'hFFF;
        endcase
    endfunction

    // --------------------------------------------------
    // pixel monitor
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            if (board_done) done_count++;
            // zero wait states, every access phase is ready
            if (psel && penable) begin
                check_value("pready", 32'd1, 32'(pready));
            end
            // a stalled pixel may not change
            if (stall_q) begin
                check_value("pix_valid (held)", 32'd1, 32'(pix_valid));
                check_value("pix_x (held)", 32'(hold_x), 32'(pix_x));
                check_value("pix_y (held)", 32'(hold_y), 32'(pix_y));
                check_value("pix_color (held)", 32'(hold_c), 32'(pix_color));
            end
            if (pix_valid && pix_ready) begin
                pix_count++;
                expect_true(exp_x.size() != 0, "pixel accepted with none expected");
                if (exp_x.size() != 0) begin
                    check_value("pix_x", 32'(exp_x.pop_front()), 32'(pix_x));
                    check_value("pix_y", 32'(exp_y.pop_front()), 32'(pix_y));
                    check_value("pix_color", 32'(exp_c.pop_front()), 32'(pix_color));
                end
            end
            stall_q = pix_valid && !pix_ready;
            hold_x = pix_x;
            hold_y = pix_y;
            hold_c = pix_color;
        end
    end

    // --------------------------------------------------
    // board model and sequencing
    // --------------------------------------------------
    // columns first, then rows, row-major inside a button
    task automatic build_model();
        int size;
        int n;
        logic on_edge;
        exp_x.delete();
        exp_y.delete();
        exp_c.delete();
        size = int'(cur_size);
        n = int'(cur_num);
        for (int r = 0; r < n; r++)
            for (int c = 0; c < n; c++)
                for (int py = 0; py < size; py++)
                    for (int px = 0; px < size; px++) begin
                        on_edge = (px < BORDER_W) || (px >= size - BORDER_W) ||
                                  (py < BORDER_W) || (py >= size - BORDER_W);
                        exp_x.push_back(coord_t'(int'(cur_x) + c * size + px));
                        exp_y.push_back(coord_t'(int'(cur_y) + r * size + py));
                        exp_c.push_back(on_edge ? cur_border : cur_fill);
                    end
    endtask

    task automatic random_board();
        cur_num = idx_t'(1 + ($unsigned($random(seed)) % 4));
        cur_size = bsize_t'(4 + ($unsigned($random(seed)) % 9));
        cur_x = coord_t'($unsigned($random(seed)) % 1024);
        cur_y = coord_t'($unsigned($random(seed)) % 1024);
        cur_fill = color_t'($random(seed));
        cur_border = color_t'($random(seed));
    endtask

    task automatic program_board();
        logic err;
        logic [31:0] vals [6];
        vals = '{32'(cur_x), 32'(cur_y), 32'(cur_size), 32'(cur_num),
                 32'(cur_fill), 32'(cur_border)};
        for (int i = 0; i < 6; i++) begin
            apb_write(SETTINGS_REGS[i], vals[i], err);
            check_value("pslverr on idle write", 0, 32'(err));
        end
    endtask

    task automatic start_board();
        logic err;
        build_model();
        pix_count = 0;
        done_before = done_count;
        apb_write(REG_CTRL, 32'h1, err);
        check_value("pslverr on start", 0, 32'(err));
    endtask

    // pix_ready toggles here when back-pressure is on
    task automatic finish_board();
        int cycles;
        int n;
        cycles = 0;
        while (done_count == done_before && cycles < BOARD_TIMEOUT) begin
            @(negedge clk);
            pix_ready = random_ready ? 1'($random(seed)) : 1'b1;
            cycles++;
        end
        pix_ready = 1'b1;
        expect_true(done_count != done_before, "board_done never arrived");
        n = int'(cur_num) * int'(cur_size);
        check_value("pixels missing", 0, 32'(exp_x.size()));
        check_value("pixel count", 32'(n * n), 32'(pix_count));
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %s: %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int e0;
        logic err;
        logic [31:0] rd;
        logic [31:0] data;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pix_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // reset values and readback
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            apb_read(apb_addr_t'(i * 4), rd);
            check_value($sformatf("reg 0x%02h after reset", i * 4), 0, rd);
        end
        for (int i = 0; i < 6; i++) begin
            data = $random(seed);
            apb_write(SETTINGS_REGS[i], data, err);
            check_value("pslverr on idle write", 0, 32'(err));
            apb_read(SETTINGS_REGS[i], rd);
            check_value($sformatf("reg 0x%02h", SETTINGS_REGS[i]),
                        data & reg_mask(SETTINGS_REGS[i]), rd);
        end
        end_test("registers", e0);

        // random boards, no back-pressure
        e0 = errors;
        for (int b = 0; b < N_BOARDS; b++) begin
            random_board();
            program_board();
            start_board();
            finish_board();
        end
        end_test("random boards", e0);

        // random boards, pix_ready toggling
        e0 = errors;
        random_ready = 1'b1;
        for (int b = 0; b < N_BOARDS; b++) begin
            random_board();
            program_board();
            start_board();
            finish_board();
        end
        random_ready = 1'b0;
        end_test("back-pressure", e0);

        // refused accesses while busy and with zero buttons
        e0 = errors;
        random_board();
        cur_num = idx_t'(2);
        program_board();
        start_board();
        apb_write(REG_FILL, 32'(~cur_fill), err);
        check_value("pslverr on busy write", 1, 32'(err));
        apb_write(REG_CTRL, 32'h1, err);
        check_value("pslverr on busy start", 1, 32'(err));
        finish_board();
        apb_read(REG_FILL, rd);
        check_value("fill after refused write", 32'(cur_fill), rd);
        apb_write(REG_BTN_NUM, 32'h0, err);
        check_value("pslverr on idle write", 0, 32'(err));
        done_before = done_count;
        pix_count = 0;
        apb_write(REG_CTRL, 32'h1, err);
        check_value("pslverr on empty start", 1, 32'(err));
        repeat (20) @(negedge clk);
        check_value("pixels of empty board", 0, 32'(pix_count));
        check_value("board_done of empty board", 0, 32'(done_count - done_before));
        apb_read(REG_STATUS, rd);
        check_value("status busy bit", 0, rd & 32'h1);
        end_test("refused accesses", e0);

        // done pulse and sticky status
        e0 = errors;
        random_board();
        program_board();
        start_board();
        finish_board();
        repeat (10) @(negedge clk);
        check_value("board_done pulses", 1, 32'(done_count - done_before));
        apb_read(REG_STATUS, rd);
        check_value("status after board", 32'h2, rd);
        start_board();
        apb_read(REG_STATUS, rd);
        check_value("status after restart", 32'h1, rd);
        finish_board();
        end_test("done status", e0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog, sized from the largest boards
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hw/board_geom_pkg.sv
hw/apb_map_pkg.sv
hw/board_settings_apb.sv
hw/tile_counter.sv
hw/draw_board.sv
hw/draw_button.sv
hw/board_renderer_top.sv
dv/board_renderer_tb.sv

//--- Makefile
# verilator build and run for the board renderer

VERILATOR ?= verilator
TOP       ?= board_renderer_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hw/*.sv dv/*.sv include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
